/* tb/glue_input.dat */
# op addr data expect, all hex; expect is checked on R and P rows
# op: L loader write, M memory write, R memory read, O port write, P port read
L 0000 3E 00
L 0001 C3 00
L 7FFF 76 00
R 0000 00 3E
R 0001 00 C3
R 7FFF 00 76
M 0001 55 00
R 0001 00 C3
M 8001 77 00
R 8001 00 77
P 0000 00 00
P 0020 00 00
P 0010 00 A5
P 0030 00 3C
P 0040 00 5A
P 00FF 00 01
O 00FF 9C 00
P 00FF 00 9C

/* verilog.f */
source/lm80c_pkg.sv
source/system_controller.sv
source/io_decoder.sv
source/memory_arbiter.sv
source/cpu_read_path.sv
source/audio_dac.sv
source/lm80c_glue.sv
tb/tb_lm80c_glue.sv

/* Makefile */
# Verilator build and run of the LM80C glue testbench

TOP = tb_lm80c_glue

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Done: errors found" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Done: no errors" sim.log; then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

/* tb/tb_lm80c_glue.sv */
// LM80C glue testbench
// Replays bus cycles from the input table, then checks strobes, enables and audio
`timescale 1ns/1ps

module tb_lm80c_glue;
	import lm80c_pkg::*;

	// Fixed peripheral read bytes
	localparam byte_t CTC_BYTE = 8'hA5;
	localparam byte_t VDP_BYTE = 8'h3C;
	localparam byte_t PSG_BYTE = 8'h5A;
	localparam int    WAIT_MAX = 20;
	localparam int    FILL_N   = 65;

	logic       ram_clock;
	logic       RESET;
	cpu_bus_t   bus_i;
	load_wr_t   load_i;
	logic       load_active_i;
	logic       boot_done_i;
	logic       reset_key_i;
	periph_rd_t periph_i;
	byte_t      ch_a_i;
	byte_t      ch_b_i;
	byte_t      ch_c_i;
	byte_t      cpu_din_o;
	byte_t      led_latch_o;
	logic       csr_n_o;
	logic       csw_n_o;
	logic       bdir_o;
	logic       bc_o;
	logic       cpu_reset_o;
	logic       wait_o;
	logic       cpu_ena_o;
	logic       vdp_ena_o;
	logic       audio_o;

	int    errors;
	int    test_errs;
	int    tests_run;
	int    tests_failed;
	// Outputs captured at the end of each bus cycle
	byte_t got_din;
	byte_t got_led;
	logic  got_csr_n;
	logic  got_csw_n;
	logic  got_bdir;
	logic  got_bc;

	lm80c_glue #(.CPU_DIV(6), .RAM_AW(16), .DAC_W(SAMPLE_W)) uut (.*);

	initial begin
		ram_clock = 1'b0;
		forever #5 ram_clock = ~ram_clock;
	end

	task automatic mismatch(input string what, input int got, input int want);
		$display("FAIL %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, want);
		errors++;
		test_errs++;
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %-12s ok", name);
		end else begin
			$display("test %-12s %0d error(s)", name, test_errs);
			tests_failed++;
		end
		test_errs = 0;
	endtask

	// mem selects a memory cycle, otherwise an I/O cycle
	function automatic cpu_bus_t make_bus(input addr_t a, input byte_t d, input logic rd,
		input logic wr, input logic mem, input logic m1);
		cpu_bus_t b;
		b.addr = a;
		b.dout = d;
		b.rd   = rd;
		b.wr   = wr;
		b.mreq = mem;
		b.iorq = !mem;
		b.m1   = m1;
		return b;
	endfunction

	// Four-clock bus cycle, outputs sampled on the last falling edge
	task automatic run_cycle(input cpu_bus_t b);
		@(posedge ram_clock);
		bus_i <= b;
		repeat (3) @(posedge ram_clock);
		@(negedge ram_clock);
		got_din   = cpu_din_o;
		got_led   = led_latch_o;
		got_csr_n = csr_n_o;
		got_csw_n = csw_n_o;
		got_bdir  = bdir_o;
		got_bc    = bc_o;
		@(posedge ram_clock);
		bus_i <= '0;
	endtask

	// Polls cpu_reset_o or wait_o on falling edges
	task automatic wait_level(input bit on_reset, input logic want, input string why);
		int n = 0;
		while ((on_reset ? cpu_reset_o : wait_o) !== want && n < WAIT_MAX) begin
			@(negedge ram_clock);
			n++;
		end
		if ((on_reset ? cpu_reset_o : wait_o) !== want) begin
			$display("Timeout: %s did not happen within %0d cycles", why, WAIT_MAX);
			errors++;
			test_errs++;
		end
	endtask

	task automatic set_loader(input logic on);
		@(posedge ram_clock);
		load_active_i <= on;
		wait_level(1'b0, on, on ? "stall for the loader" : "stall release");
	endtask

	task automatic load_byte(input addr_t a, input byte_t d);
		@(posedge ram_clock);
		load_i <= '{addr: a, data: d, wr: 1'b1};
		@(posedge ram_clock);
		load_i.wr <= 1'b0;
	endtask

	initial begin : main
		int    fd;
		string line;
		byte   op;
		addr_t a;
		byte_t d;
		byte_t want;
		logic  loading;
		int    ones;
		int    exp_ones;
		int    ena_cpu;
		int    ena_vdp;
		addr_t fill_addr [FILL_N];
		byte_t fill_data [FILL_N];

		void'($urandom(32'hff67));
		RESET         = 1'b1;
		bus_i         = '0;
		load_i        = '0;
		load_active_i = 1'b0;
		boot_done_i   = 1'b0;
		reset_key_i   = 1'b0;
		periph_i      = '{ctc: CTC_BYTE, vdp: VDP_BYTE, psg: PSG_BYTE};
		ch_a_i        = '0;
		ch_b_i        = '0;
		ch_c_i        = '0;
		errors        = 0;
		test_errs     = 0;
		tests_run     = 0;
		tests_failed  = 0;
		repeat (10) @(posedge ram_clock);
		RESET <= 1'b0;
		@(negedge ram_clock);

		// Boot holds the CPU, load stalls it, reset key resets it
		if (cpu_reset_o !== 1'b1 || wait_o !== 1'b1)
			mismatch("reset and wait after RESET", {cpu_reset_o, wait_o}, 2'b11);
		@(posedge ram_clock);
		boot_done_i <= 1'b1;
		wait_level(1'b1, 1'b0, "CPU reset release after boot");
		wait_level(1'b0, 1'b0, "stall release after boot");
		set_loader(1'b1);
		set_loader(1'b0);
		@(posedge ram_clock);
		reset_key_i <= 1'b1;
		@(negedge ram_clock);
		if (cpu_reset_o !== 1'b1)
			mismatch("cpu_reset_o with reset key held", cpu_reset_o, 1);
		@(posedge ram_clock);
		reset_key_i <= 1'b0;
		wait_level(1'b1, 1'b0, "CPU reset release after the key");
		close_test("sequencer");

		// Table rows, loader rows run with the CPU stalled
		if (led_latch_o !== LED_RESET)
			mismatch("LED latch after reset", led_latch_o, LED_RESET);
		// Nonzero ROM byte behind the SIO port address, unlike the port's 0
		set_loader(1'b1);
		load_byte({8'h00, PORT_SIO, 4'h0}, 8'hE7);
		loading = 1'b1;
		fd = $fopen("tb/glue_input.dat", "r");
		if (fd == 0) begin
			$display("Cannot open tb/glue_input.dat, no bus cycles replayed");
			errors++;
			test_errs++;
		end
		while (fd != 0 && !$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 7 || line[0] == "#")
				continue;
			void'($sscanf(line, "%c %h %h %h", op, a, d, want));
			if ((op == "L") != loading) begin
				loading = (op == "L");
				set_loader(loading);
			end
			case (op)
				"L": load_byte(a, d);
				"M": run_cycle(make_bus(a, d, 1'b0, 1'b1, 1'b1, 1'b0));
				"R": run_cycle(make_bus(a, 8'h00, 1'b1, 1'b0, 1'b1, 1'b0));
				"O": run_cycle(make_bus(a, d, 1'b0, 1'b1, 1'b0, 1'b0));
				"P": run_cycle(make_bus(a, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0));
				default: begin
					$display("Unknown operation %c in the input table", op);
					errors++;
					test_errs++;
				end
			endcase
			if ((op == "R" || op == "P") && got_din !== want)
				mismatch($sformatf("%c read of %h", op, a), got_din, want);
			if (op == "O" && a[7:0] == PORT_LED && got_led !== d)
				mismatch("LED latch after port write", got_led, d);
		end
		if (fd != 0)
			$fclose(fd);
		if (loading)
			set_loader(1'b0);
		close_test("bus replay");

		// Random bytes across the writable window, both bounds included
		for (int i = 0; i < FILL_N; i++) begin
			fill_addr[i] = (i == FILL_N - 1) ? RAM_HI : RAM_LO + addr_t'(i * 257);
			fill_data[i] = byte_t'($urandom);
			run_cycle(make_bus(fill_addr[i], fill_data[i], 1'b0, 1'b1, 1'b1, 1'b0));
		end
		for (int i = 0; i < FILL_N; i++) begin
			run_cycle(make_bus(fill_addr[i], 8'h00, 1'b1, 1'b0, 1'b1, 1'b0));
			if (got_din !== fill_data[i])
				mismatch($sformatf("RAM read of %h", fill_addr[i]), got_din, fill_data[i]);
		end
		close_test("ram window");

		// IORQ with M1, no RD
		run_cycle(make_bus(16'h0000, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1));
		if (got_din !== CTC_BYTE)
			mismatch("interrupt vector", got_din, CTC_BYTE);
		close_test("int ack");

		run_cycle(make_bus({8'h00, PORT_VDP, 4'h0}, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0));
		if (got_csr_n !== 1'b0 || got_csw_n !== 1'b1)
			mismatch("video read csr_n/csw_n", {got_csr_n, got_csw_n}, 2'b01);
		run_cycle(make_bus({8'h00, PORT_VDP, 4'h0}, 8'h11, 1'b0, 1'b1, 1'b0, 1'b0));
		if (got_csr_n !== 1'b1 || got_csw_n !== 1'b0)
			mismatch("video write csr_n/csw_n", {got_csr_n, got_csw_n}, 2'b10);
		// A0 low, address latch
		run_cycle(make_bus({8'h00, PORT_PSG, 4'h0}, 8'h07, 1'b0, 1'b1, 1'b0, 1'b0));
		if (got_bdir !== 1'b1 || got_bc !== 1'b1)
			mismatch("sound write bdir/bc", {got_bdir, got_bc}, 2'b11);
		close_test("strobes");

		ena_cpu = 0;
		ena_vdp = 0;
		repeat (48) begin
			@(negedge ram_clock);
			if (cpu_ena_o === 1'b1)
				ena_cpu++;
			if (vdp_ena_o === 1'b1)
				ena_vdp++;
		end
		if (ena_cpu != 8)
			mismatch("cpu_ena_o pulses in 48 cycles", ena_cpu, 8);
		if (ena_vdp != 24)
			mismatch("vdp_ena_o pulses in 48 cycles", ena_vdp, 24);
		close_test("enables");

		ones = 0;
		repeat (256) begin
			@(negedge ram_clock);
			if (audio_o !== 1'b0)
				ones++;
		end
		if (ones != 0)
			mismatch("audio ones with silent channels", ones, 0);
		@(posedge ram_clock);
		ch_a_i <= 8'h40;
		ch_b_i <= 8'h20;
		ch_c_i <= 8'h13;
		// Density of ones is the left-aligned sum over full scale
		exp_ones = 4096 * (8'h40 + 8'h20 + 8'h13) * 64 / 65536;
		ones = 0;
		repeat (4096) begin
			@(negedge ram_clock);
			if (audio_o === 1'b1)
				ones++;
		end
		if (ones < exp_ones - 1 || ones > exp_ones + 1)
			mismatch("audio ones in 4096 cycles", ones, exp_ones);
		close_test("audio");

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* source/lm80c_glue.sv */
// LM80C system glue top level
// Sequencer, port decoder, RAM arbiter, read path and audio DAC
`timescale 1ns/1ps

module lm80c_glue #(
	parameter int CPU_DIV = 6,
	parameter int RAM_AW  = 16,
	parameter int DAC_W   = lm80c_pkg::SAMPLE_W
) (
	input  logic                   ram_clock,
	input  logic                   RESET,
	input  lm80c_pkg::cpu_bus_t    bus_i,
	input  lm80c_pkg::load_wr_t    load_i,
	input  logic                   load_active_i,
	input  logic                   boot_done_i,
	input  logic                   reset_key_i,
	input  lm80c_pkg::periph_rd_t  periph_i,
	input  lm80c_pkg::byte_t       ch_a_i,
	input  lm80c_pkg::byte_t       ch_b_i,
	input  lm80c_pkg::byte_t       ch_c_i,
	output lm80c_pkg::byte_t       cpu_din_o,
	output lm80c_pkg::byte_t       led_latch_o,
	output logic                   csr_n_o,
	output logic                   csw_n_o,
	output logic                   bdir_o,
	output logic                   bc_o,
	output logic                   cpu_reset_o,
	output logic                   wait_o,
	output logic                   cpu_ena_o,
	output logic                   vdp_ena_o,
	output logic                   audio_o
);
	import lm80c_pkg::*;

	logic    loader_owns;
	io_sel_t sel;
	byte_t   ram_q;

	// Reset, wait and clock enables
	system_controller #(.CPU_DIV(CPU_DIV)) u_ctrl (
		.ram_clock(ram_clock), .RESET(RESET),
		.boot_done_i(boot_done_i), .load_active_i(load_active_i),
		.reset_key_i(reset_key_i), .cpu_reset_o(cpu_reset_o),
		.wait_o(wait_o), .loader_owns_o(loader_owns),
		.cpu_ena_o(cpu_ena_o), .vdp_ena_o(vdp_ena_o)
	);

	io_decoder u_dec (
		.ram_clock(ram_clock), .RESET(RESET), .bus_i(bus_i), .sel_o(sel),
		.csr_n_o(csr_n_o), .csw_n_o(csw_n_o), .bdir_o(bdir_o), .bc_o(bc_o)
	);

	// System RAM behind the arbiter
	memory_arbiter #(.RAM_AW(RAM_AW)) u_arb (
		.ram_clock(ram_clock), .bus_i(bus_i), .load_i(load_i),
		.loader_owns_i(loader_owns), .ram_sel_i(sel.ram), .ram_q_o(ram_q)
	);

	cpu_read_path u_rd (
		.ram_clock(ram_clock), .RESET(RESET), .bus_i(bus_i), .sel_i(sel),
		.periph_i(periph_i), .ram_q_i(ram_q),
		.cpu_din_o(cpu_din_o), .led_latch_o(led_latch_o)
	);

	// Sound chip channels to the bitstream
	audio_dac #(.DAC_W(DAC_W)) u_dac (
		.ram_clock(ram_clock), .RESET(RESET),
		.ch_a_i(ch_a_i), .ch_b_i(ch_b_i), .ch_c_i(ch_c_i), .audio_o(audio_o)
	);

endmodule

/* source/audio_dac.sv */
// LM80C audio output
// Three-channel mixer into a first-order sigma-delta DAC
`timescale 1ns/1ps

module audio_dac #(
	parameter int DAC_W = lm80c_pkg::SAMPLE_W
) (
	input  logic              ram_clock,
	input  logic              RESET,
	input  lm80c_pkg::byte_t  ch_a_i,
	input  lm80c_pkg::byte_t  ch_b_i,
	input  lm80c_pkg::byte_t  ch_c_i,
	output logic              audio_o
);
	logic [9:0]       ch_sum;
	logic [DAC_W-1:0] sample;
	logic [DAC_W-1:0] acc;
	logic [DAC_W:0]   acc_next;

	// Mix, 10 bits holds three full-scale bytes
	assign ch_sum = 10'(ch_a_i) + 10'(ch_b_i) + 10'(ch_c_i);
	// Left-align the mix
	assign sample = {ch_sum, {(DAC_W - 10){1'b0}}};

	assign acc_next = {1'b0, acc} + {1'b0, sample};

	// Carry out is the bitstream
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			acc     <= '0;
			audio_o <= 1'b0;
		end else begin
			acc     <= acc_next[DAC_W-1:0];
			audio_o <= acc_next[DAC_W];
		end
	end

endmodule

/* source/cpu_read_path.sv */
// LM80C CPU read path
// Registered read-data mux, interrupt vector and LED port latch
`timescale 1ns/1ps

module cpu_read_path (
	input  logic                   ram_clock,
	input  logic                   RESET,
	input  lm80c_pkg::cpu_bus_t    bus_i,
	input  lm80c_pkg::io_sel_t     sel_i,
	input  lm80c_pkg::periph_rd_t  periph_i,
	input  lm80c_pkg::byte_t       ram_q_i,
	output lm80c_pkg::byte_t       cpu_din_o,
	output lm80c_pkg::byte_t       led_latch_o
);
	import lm80c_pkg::*;

	byte_t rd_mux;

	// First matching source wins
	always_comb begin
		if (sel_i.pio || sel_i.sio)
			rd_mux = '0;
		else if (sel_i.ctc)
			rd_mux = periph_i.ctc;
		else if (sel_i.vdp)
			rd_mux = periph_i.vdp;
		else if (sel_i.psg)
			rd_mux = periph_i.psg;
		else if (sel_i.led)
			rd_mux = led_latch_o;
		else
			rd_mux = ram_q_i;
	end

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cpu_din_o   <= '0;
			led_latch_o <= LED_RESET;
		end else begin
			if (bus_i.rd)
				cpu_din_o <= rd_mux;
			else if (bus_i.iorq && bus_i.m1)
				cpu_din_o <= periph_i.ctc; // Interrupt acknowledge, CTC vector
			// LED port write
			if (sel_i.led && bus_i.wr)
				led_latch_o <= bus_i.dout;
		end
	end

endmodule

/* source/memory_arbiter.sv */
// LM80C memory arbiter
// Loader or CPU as RAM master, ROM write protection, 64 KiB system RAM
`timescale 1ns/1ps

module memory_arbiter #(
	parameter int RAM_AW = 16
) (
	input  logic                 ram_clock,
	input  lm80c_pkg::cpu_bus_t  bus_i,
	input  lm80c_pkg::load_wr_t  load_i,
	input  logic                 loader_owns_i,
	input  logic                 ram_sel_i,
	output lm80c_pkg::byte_t     ram_q_o
);
	import lm80c_pkg::*;

	addr_t ram_addr;
	byte_t ram_din;
	logic  ram_we;
	byte_t mem [2**RAM_AW];

	// Master select
	always_comb begin
		if (loader_owns_i) begin
			ram_addr = load_i.addr;
			ram_din  = load_i.data;
			ram_we   = load_i.wr;
		end else begin
			ram_addr = bus_i.addr;
			ram_din  = bus_i.dout;
			// ram_sel only covers the window, so ROM stays intact
			ram_we   = bus_i.wr && bus_i.mreq && ram_sel_i;
		end
	end

	// Synchronous RAM, registered read
	always_ff @(posedge ram_clock) begin
		if (ram_we)
			mem[ram_addr[RAM_AW-1:0]] <= ram_din;
		ram_q_o <= mem[ram_addr[RAM_AW-1:0]];
	end

	// Loader writes only while the sequencer hands it the RAM
	a_loader_owner: assert property (@(posedge ram_clock)
		!(load_i.wr && !loader_owns_i));

endmodule

/* source/io_decoder.sv */
// LM80C I/O port decoder
// Registered chip selects, video read/write strobes, sound chip bus control
`timescale 1ns/1ps

module io_decoder (
	input  logic                 ram_clock,
	input  logic                 RESET,
	input  lm80c_pkg::cpu_bus_t  bus_i,
	output lm80c_pkg::io_sel_t   sel_o,
	output logic                 csr_n_o,
	output logic                 csw_n_o,
	output logic                 bdir_o,
	output logic                 bc_o
);
	import lm80c_pkg::*;

	logic io_cyc;

	// Port cycle, not a memory cycle
	assign io_cyc = bus_i.iorq && !bus_i.mreq;

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			sel_o   <= '0;
			csr_n_o <= 1'b1;
			csw_n_o <= 1'b1;
			bdir_o  <= 1'b0;
			bc_o    <= 1'b0;
		end else begin
			// Peripheral selects on upper nibble of the port
			sel_o.pio <= io_cyc && (bus_i.addr[7:4] == PORT_PIO);
			sel_o.ctc <= io_cyc && (bus_i.addr[7:4] == PORT_CTC);
			sel_o.sio <= io_cyc && (bus_i.addr[7:4] == PORT_SIO);
			sel_o.vdp <= io_cyc && (bus_i.addr[7:4] == PORT_VDP);
			sel_o.psg <= io_cyc && (bus_i.addr[7:4] == PORT_PSG);
			// LED decodes the whole byte
			sel_o.led <= io_cyc && (bus_i.addr[7:0] == PORT_LED);
			// Writable RAM window only
			sel_o.ram <= bus_i.mreq && (bus_i.addr >= RAM_LO) && (bus_i.addr <= RAM_HI);

			// Video strobes from last cycle's select
			csr_n_o <= ~(bus_i.rd && bus_i.iorq && sel_o.vdp);
			csw_n_o <= ~(bus_i.wr && bus_i.iorq && sel_o.vdp);

			// Sound chip: write sets BDIR, A0 low selects the address latch
			bdir_o <= bus_i.wr && sel_o.psg;
			bc_o   <= ~bus_i.addr[0] && sel_o.psg;
		end
	end

	// Port map never overlaps
	a_one_port: assert property (@(posedge ram_clock) disable iff (RESET)
		$onehot0({sel_o.pio, sel_o.ctc, sel_o.sio, sel_o.vdp, sel_o.psg, sel_o.led}));

endmodule

/* source/system_controller.sv */
// LM80C system controller
// Boot/load/run sequencer, CPU reset and wait, clock-enable divider
`timescale 1ns/1ps

module system_controller #(
	parameter int CPU_DIV = 6
) (
	input  logic ram_clock,
	input  logic RESET,
	input  logic boot_done_i,
	input  logic load_active_i,
	input  logic reset_key_i,
	output logic cpu_reset_o,
	output logic wait_o,
	output logic loader_owns_o,
	output logic cpu_ena_o,
	output logic vdp_ena_o
);
	import lm80c_pkg::*;

	localparam int CNT_W = (CPU_DIV > 1) ? $clog2(CPU_DIV) : 1;

	seq_state_t        state;
	seq_state_t        state_next;
	logic [CNT_W-1:0]  cpu_cnt;
	logic [2:0]        vdp_cnt;

	// Boot must finish before anything else
	always_comb begin
		state_next = state;
		if (state == SEQ_BOOT && !boot_done_i)
			state_next = SEQ_BOOT;
		else if (load_active_i)
			state_next = SEQ_LOAD;
		else
			state_next = SEQ_RUN;
	end

	always_ff @(posedge ram_clock) begin
		if (RESET)
			state <= SEQ_BOOT;
		else
			state <= state_next;
	end

	// CPU held in reset while booting or key pressed
	assign cpu_reset_o   = (state == SEQ_BOOT) || reset_key_i;
	// Stall the CPU whenever the loader may touch RAM
	assign wait_o        = (state != SEQ_RUN);
	assign loader_owns_o = (state == SEQ_LOAD) || (state == SEQ_BOOT);

	// Divider counters
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cpu_cnt <= '0;
			vdp_cnt <= '0;
		end else begin
			vdp_cnt <= vdp_cnt + 3'd1;
			if (cpu_cnt == CNT_W'(CPU_DIV - 1))
				cpu_cnt <= '0;
			else
				cpu_cnt <= cpu_cnt + 1'b1;
		end
	end

	assign cpu_ena_o = (cpu_cnt == '0);
	// Even counts of the mod-8 counter, half rate
	assign vdp_ena_o = ~vdp_cnt[0];

	// First cycle out of reset keeps the CPU stalled and the enable phase aligned
	a_reset_exit: assert property (@(posedge ram_clock) RESET |=> (wait_o && cpu_ena_o));

endmodule

/* source/lm80c_pkg.sv */
// LM80C system glue shared definitions
// Bus structs, width types, I/O port map and sequencer states
package lm80c_pkg;

	// Widths that carry a meaning
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;

	// Z80 bus, active high
	typedef struct packed {
		addr_t addr;
		byte_t dout;
		logic  rd;
		logic  wr;
		logic  mreq;
		logic  iorq;
		logic  m1;
	} cpu_bus_t;

	// Loader write stream
	typedef struct packed {
		addr_t addr;
		byte_t data;
		logic  wr;
	} load_wr_t;

	// Read bytes from the peripheral chips
	typedef struct packed {
		byte_t ctc;
		byte_t vdp;
		byte_t psg;
	} periph_rd_t;

	// Registered chip selects
	typedef struct packed {
		logic pio;
		logic ctc;
		logic sio;
		logic vdp;
		logic psg;
		logic led;
		logic ram;
	} io_sel_t;

	// Boot, load and run phases
	typedef enum logic [1:0] {
		SEQ_BOOT,
		SEQ_LOAD,
		SEQ_RUN
	} seq_state_t;

	// Port map on A[7:4]
	localparam logic [3:0] PORT_PIO = 4'd0;
	localparam logic [3:0] PORT_CTC = 4'd1;
	localparam logic [3:0] PORT_SIO = 4'd2;
	localparam logic [3:0] PORT_VDP = 4'd3;
	localparam logic [3:0] PORT_PSG = 4'd4;
	// Debug LED sits on the full low byte
	localparam byte_t PORT_LED = 8'hFF;

	// CPU-writable RAM window
	localparam addr_t RAM_LO = 16'h8000;
	localparam addr_t RAM_HI = 16'hBFFF;

	localparam byte_t LED_RESET = 8'd1;
	localparam int    SAMPLE_W  = 16;

endpackage
